/* alu_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_dispatch #(
    parameter int NUM_THREADS = 4
) (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire                                       req_valid,
    output logic                                      req_ready,
    input  wire [simt_pkg::NW_BITS-1:0]               req_wid,
    input  wire [NUM_THREADS-1:0]                     req_tmask,
    input  wire [simt_pkg::XLEN-1:0]                  req_pc,
    input  wire simt_pkg::alu_op_e                    req_op,
    input  wire                                       req_is_br,
    input  wire simt_pkg::br_op_e                     req_br_op,
    input  wire                                       req_use_pc,
    input  wire                                       req_use_imm,
    input  wire [simt_pkg::XLEN-1:0]                  req_imm,
    input  wire [simt_pkg::tid_bits(NUM_THREADS)-1:0] req_tid,
    input  wire [simt_pkg::NR_BITS-1:0]               req_rd,
    input  wire                                       req_wb,
    input  wire [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] req_rs1_data,
    input  wire [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] req_rs2_data,
    alu_req_if.master                                 alu_req
);

    // Conditional branches compare rs1 against rs2, so B keeps rs2
    wire is_cond_br = req_is_br && (req_br_op != simt_pkg::JAL) && (req_br_op != simt_pkg::JALR);
    wire accept     = req_valid && req_ready;

    assign req_ready = alu_req.ready || !alu_req.valid;

    always_ff @(posedge clk) begin
        if (reset)
            alu_req.valid <= 1'b0;
        else if (req_ready)
            alu_req.valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_req.wid      <= req_wid;
            alu_req.tmask    <= req_tmask;
            alu_req.pc       <= req_pc;
            alu_req.op       <= req_op;
            alu_req.is_br    <= req_is_br;
            alu_req.br_op    <= req_br_op;
            alu_req.tid      <= req_tid;
            alu_req.rd       <= req_rd;
            alu_req.wb       <= req_wb;
            alu_req.imm      <= req_imm;
            alu_req.rs1_data <= req_rs1_data;
            alu_req.rs2_data <= req_rs2_data;
            alu_req.a_data   <= req_use_pc ? {NUM_THREADS{req_pc}} : req_rs1_data;  // PC in all lanes
            alu_req.b_data   <= (req_use_imm && !is_cond_br) ? {NUM_THREADS{req_imm}}
                                                             : req_rs2_data;
        end
    end

endmodule

`default_nettype wire

/* alu_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface alu_req_if #(
    parameter int NUM_THREADS = 4
);
    logic                                       valid;
    logic                                       ready;
    logic [simt_pkg::NW_BITS-1:0]               wid;
    logic [NUM_THREADS-1:0]                     tmask;
    logic [simt_pkg::XLEN-1:0]                  pc;
    simt_pkg::alu_op_e                          op;
    logic                                       is_br;
    simt_pkg::br_op_e                           br_op;
    logic [simt_pkg::tid_bits(NUM_THREADS)-1:0] tid;    // Lane that resolves the branch
    logic [simt_pkg::NR_BITS-1:0]               rd;
    logic                                       wb;
    logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] a_data;
    logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] b_data;
    logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] rs1_data;
    logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] rs2_data;
    logic [simt_pkg::XLEN-1:0]                  imm;

    modport master (
        output valid, wid, tmask, pc, op, is_br, br_op, tid, rd, wb,
        output a_data, b_data, rs1_data, rs2_data, imm,
        input  ready
    );

    modport slave (
        input  valid, wid, tmask, pc, op, is_br, br_op, tid, rd, wb,
        input  a_data, b_data, rs1_data, rs2_data, imm,
        output ready
    );

endinterface

`default_nettype wire

/* alu_tb_model.svh */
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Corner values show up often, for compares and shift amounts 0 and 31
function automatic logic [31:0] pick_operand(input logic [31:0] sel, input logic [31:0] rnd);
    case (sel[2:0])
        3'd0:    return 32'h0000_0000;
        3'd1:    return 32'h8000_0000;
        3'd2:    return 32'hffff_ffff;
        3'd3:    return 32'h0000_001f;
        default: return rnd;
    endcase
endfunction

function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
    return (x[31] != y[31]) ? x[31] : (x < y);     // Negative side is smaller
endfunction

function automatic logic [31:0] lane_result(input simt_pkg::alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] rs1);
    logic [31:0] fill;
    fill = rs1[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0;   // Sign bits for SRA
    case (op)
        simt_pkg::SUB:  return a - b;
        simt_pkg::SLT:  return {31'd0, signed_less(rs1, b)};
        simt_pkg::SLTU: return {31'd0, rs1 < b};
        simt_pkg::AND:  return rs1 & b;
        simt_pkg::OR:   return rs1 | b;
        simt_pkg::XOR:  return rs1 ^ b;
        simt_pkg::SLL:  return rs1 << b[4:0];
        simt_pkg::SRL:  return rs1 >> b[4:0];
        simt_pkg::SRA:  return (rs1 >> b[4:0]) | fill;
        default:        return a + b;                    // ADD, LUI, AUIPC
    endcase
endfunction

function automatic logic branch_taken_model(input simt_pkg::br_op_e op, input logic [31:0] x,
                                            input logic [31:0] y);
    case (op)
        simt_pkg::BEQ:  return x == y;
        simt_pkg::BNE:  return x != y;
        simt_pkg::BLT:  return signed_less(x, y);
        simt_pkg::BGE:  return !signed_less(x, y);
        simt_pkg::BLTU: return x < y;
        simt_pkg::BGEU: return x >= y;
        default:        return 1'b1;                     // Jumps
    endcase
endfunction

`endif

/* alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_tb;

    localparam int NT      = 4;
    localparam int NUM_REQ = 300;
    localparam int TIMEOUT = 20 * NUM_REQ + 200;

    typedef logic [127:0] word_t;
    typedef struct packed {
        logic [1:0]          kind;     // 0 arith, 1 compare and shift, 2 branch
        logic [1:0]          wid;
        logic [NT-1:0]       tmask;
        logic [31:0]         pc;
        logic [4:0]          rd;
        logic                wb;
        logic [NT-1:0][31:0] data;
    } commit_exp_t;
    typedef struct packed {
        logic [1:0]  wid;
        logic        taken;
        logic [31:0] dest;
    } branch_exp_t;

    logic                clk = 1'b0;
    logic                reset, req_valid, req_ready, req_is_br, req_use_pc, req_use_imm;
    logic                req_wb, branch_valid, branch_taken, commit_valid, commit_ready, commit_wb;
    logic [1:0]          req_wid, req_tid, branch_wid, commit_wid;
    logic [4:0]          req_rd, commit_rd;
    logic [31:0]         req_pc, req_imm, branch_dest, commit_pc;
    logic [NT-1:0]       req_tmask, commit_tmask;
    logic [NT-1:0][31:0] req_rs1_data, req_rs2_data, commit_data;
    simt_pkg::alu_op_e   req_op;
    simt_pkg::br_op_e    req_br_op;

    logic [31:0] stim_state  = 32'd77;
    logic [31:0] ready_state = 32'd77 ^ 32'h9e37_79b9;   // Own stream for commit_ready
    logic [31:0] idle;
    int          low_run;
    int          cycle_count;
    string       tn;
    commit_exp_t exp_q[$];
    branch_exp_t br_q[$];
    commit_exp_t mon_c;
    branch_exp_t mon_b;

    `include "alu_tb_model.svh"

    alu_top #(.NUM_THREADS(NT), .FIFO_DEPTH(4)) alu_top_i (.*);

    function automatic logic [31:0] rand_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_field(input string test, input string field, input word_t exp,
                               input word_t got);
        assert (got === exp)
            else fail_run($sformatf("Fail %s %s expected %0h actual %0h", test, field, exp, got));
    endtask

    task automatic send_request();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        logic [31:0] lane;
        logic        cond_br;
        logic        accepted;
        commit_exp_t ce;
        branch_exp_t be;
        r = rand_stim();
        s = rand_stim();
        ce.kind     = 2'(r % 3);
        req_wid     = r[3:2];
        req_tmask   = r[7:4];
        req_wb      = r[8];
        req_rd      = (r[10:9] == 2'd0) ? 5'd0 : r[15:11];    // x0 about one time in four
        req_tid     = r[17:16];
        req_use_pc  = r[18];
        req_use_imm = r[19];
        req_pc      = {s[31:2], 2'b00};
        req_imm     = pick_operand(r >> 20, s ^ 32'h5bd1_e995);
        for (int i = 0; i < NT; i++) begin
            t = rand_stim();
            s = rand_stim();
            req_rs1_data[i] = pick_operand(t, s);
            req_rs2_data[i] = pick_operand(t >> 3, xorshift32(s));
        end
        t = rand_stim();
        req_is_br = 1'b0;
        req_br_op = simt_pkg::BEQ;
        case (ce.kind)
            2'd0:
                case (t % 7)
                    0: req_op = simt_pkg::ADD;
                    1: req_op = simt_pkg::SUB;
                    2: req_op = simt_pkg::AND;
                    3: req_op = simt_pkg::OR;
                    4: req_op = simt_pkg::XOR;
                    5: req_op = simt_pkg::LUI;
                    default: req_op = simt_pkg::AUIPC;
                endcase
            2'd1: begin
                req_use_pc = 1'b0;
                case (t % 5)
                    0: req_op = simt_pkg::SLT;
                    1: req_op = simt_pkg::SLTU;
                    2: req_op = simt_pkg::SLL;
                    3: req_op = simt_pkg::SRL;
                    default: req_op = simt_pkg::SRA;
                endcase
            end
            default: begin
                req_is_br = 1'b1;
                req_op    = simt_pkg::ADD;
                req_br_op = simt_pkg::br_op_e'(t[2:0]);
                if (t[4:3] == 2'd0)
                    req_rs2_data[req_tid] = req_rs1_data[req_tid];   // Equal operands
            end
        endcase
        if (req_op == simt_pkg::LUI || req_op == simt_pkg::AUIPC) begin
            req_use_pc  = (req_op == simt_pkg::AUIPC);
            req_use_imm = 1'b1;
            if (req_op == simt_pkg::LUI)
                req_rs1_data = '0;                                   // A is zero for LUI
        end
        cond_br = req_is_br && (req_br_op != simt_pkg::JAL) && (req_br_op != simt_pkg::JALR);
        for (int i = 0; i < NT; i++) begin
            lane = lane_result(req_op, req_use_pc ? req_pc : req_rs1_data[i],
                               (req_use_imm && !cond_br) ? req_imm : req_rs2_data[i],
                               req_rs1_data[i]);
            if (req_is_br)
                lane = req_pc + 32'd4;
            ce.data[i] = req_tmask[i] ? lane : 32'd0;
        end
        ce.wid   = req_wid;
        ce.tmask = req_tmask;
        ce.pc    = req_pc;
        ce.rd    = req_rd;
        ce.wb    = req_wb && (req_rd != 5'd0);
        be.wid   = req_wid;
        be.taken = branch_taken_model(req_br_op, req_rs1_data[req_tid], req_rs2_data[req_tid]);
        be.dest  = (req_use_pc ? req_pc : req_rs1_data[req_tid]) + req_imm;
        req_valid = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        exp_q.push_back(ce);
        if (req_is_br)
            br_q.push_back(be);
    endtask

    initial begin
        forever #4 clk = ~clk;
    end

    // Mostly ready, with long stalls that fill the FIFO
    initial begin
        commit_ready = 1'b0;
        low_run      = 0;
        forever begin
            @(posedge clk);
            #1;
            ready_state = xorshift32(ready_state);
            if (low_run == 0 && ready_state[4:0] == 5'd0)
                low_run = 12 + int'(ready_state[10:6]);
            commit_ready = (low_run == 0) && (ready_state[13:11] != 3'd0);
            if (low_run != 0)
                low_run--;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        fail_run($sformatf("Timeout after %0d cycles, %0d commits still expected",
                           cycle_count, exp_q.size()));
    end

    always @(negedge clk) begin
        if (reset) begin
            assert (!commit_valid && !branch_valid)
                else fail_run("A valid output was high during reset");
        end else begin
            if (branch_valid) begin
                assert (br_q.size() != 0) begin
                    mon_b = br_q.pop_front();
                    check_field("branch", "branch_wid", word_t'(mon_b.wid), word_t'(branch_wid));
                    check_field("branch", "branch_taken", word_t'(mon_b.taken),
                                word_t'(branch_taken));
                    check_field("branch", "branch_dest", word_t'(mon_b.dest),
                                word_t'(branch_dest));
                end else fail_run("Branch pulse with no branch outstanding");
            end
            if (commit_valid) begin
                assert (exp_q.size() != 0) begin
                    if (commit_ready) begin
                        mon_c = exp_q.pop_front();
                        tn = (mon_c.kind == 2'd0) ? "arith"
                           : (mon_c.kind == 2'd1) ? "compare_shift" : "branch";
                        check_field(tn, "commit_wid", word_t'(mon_c.wid), word_t'(commit_wid));
                        check_field(tn, "commit_tmask", word_t'(mon_c.tmask),
                                    word_t'(commit_tmask));
                        check_field(tn, "commit_pc", word_t'(mon_c.pc), word_t'(commit_pc));
                        check_field(tn, "commit_rd", word_t'(mon_c.rd), word_t'(commit_rd));
                        check_field(tn, "commit_wb", word_t'(mon_c.wb), word_t'(commit_wb));
                        check_field(tn, "commit_data", word_t'(mon_c.data),
                                    word_t'(commit_data));
                    end
                end else fail_run("commit_valid high with no request outstanding");
            end
        end
    end

    initial begin
        reset        = 1'b1;
        req_op       = simt_pkg::ADD;
        req_br_op    = simt_pkg::BEQ;
        {req_valid, req_is_br, req_use_pc, req_use_imm, req_wb} = '0;
        {req_wid, req_tmask, req_pc, req_imm, req_tid, req_rd} = '0;
        {req_rs1_data, req_rs2_data} = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_REQ; n++) begin
            idle = rand_stim();
            if (idle[2:0] == 3'd0) begin
                repeat (int'(idle[4:3]) + 1) @(posedge clk);
                #1;
            end
            send_request();
        end
        while (exp_q.size() != 0 || br_q.size() != 0)
            @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* alu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_top #(
    parameter int NUM_THREADS = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        req_valid,
    output logic                                       req_ready,
    input  wire [simt_pkg::NW_BITS-1:0]                req_wid,
    input  wire [NUM_THREADS-1:0]                      req_tmask,
    input  wire [simt_pkg::XLEN-1:0]                   req_pc,
    input  wire simt_pkg::alu_op_e                     req_op,
    input  wire                                        req_is_br,
    input  wire simt_pkg::br_op_e                      req_br_op,
    input  wire                                        req_use_pc,
    input  wire                                        req_use_imm,
    input  wire [simt_pkg::XLEN-1:0]                   req_imm,
    input  wire [simt_pkg::tid_bits(NUM_THREADS)-1:0]  req_tid,
    input  wire [simt_pkg::NR_BITS-1:0]                req_rd,
    input  wire                                        req_wb,
    input  wire [NUM_THREADS-1:0][simt_pkg::XLEN-1:0]  req_rs1_data,
    input  wire [NUM_THREADS-1:0][simt_pkg::XLEN-1:0]  req_rs2_data,
    output logic                                       branch_valid,
    output logic                                       branch_taken,
    output logic [simt_pkg::NW_BITS-1:0]               branch_wid,
    output logic [simt_pkg::XLEN-1:0]                  branch_dest,
    output logic                                       commit_valid,
    input  wire                                        commit_ready,
    output logic [simt_pkg::NW_BITS-1:0]               commit_wid,
    output logic [NUM_THREADS-1:0]                     commit_tmask,
    output logic [simt_pkg::XLEN-1:0]                  commit_pc,
    output logic [simt_pkg::NR_BITS-1:0]               commit_rd,
    output logic                                       commit_wb,
    output logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] commit_data
);

    alu_req_if #(.NUM_THREADS(NUM_THREADS)) alu_req ();
    commit_if  #(.NUM_THREADS(NUM_THREADS)) alu_pkt ();     // ALU into FIFO
    commit_if  #(.NUM_THREADS(NUM_THREADS)) fifo_pkt ();    // FIFO into writeback

    alu_dispatch #(.NUM_THREADS(NUM_THREADS)) alu_dispatch_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_wid      (req_wid),
        .req_tmask    (req_tmask),
        .req_pc       (req_pc),
        .req_op       (req_op),
        .req_is_br    (req_is_br),
        .req_br_op    (req_br_op),
        .req_use_pc   (req_use_pc),
        .req_use_imm  (req_use_imm),
        .req_imm      (req_imm),
        .req_tid      (req_tid),
        .req_rd       (req_rd),
        .req_wb       (req_wb),
        .req_rs1_data (req_rs1_data),
        .req_rs2_data (req_rs2_data),
        .alu_req      (alu_req.master)
    );

    alu_unit #(.NUM_THREADS(NUM_THREADS)) alu_unit_i (
        .clk          (clk),
        .reset        (reset),
        .alu_req      (alu_req.slave),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .branch_wid   (branch_wid),
        .branch_dest  (branch_dest),
        .result       (alu_pkt.master)
    );

    commit_fifo #(
        .NUM_THREADS (NUM_THREADS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) commit_fifo_i (
        .clk   (clk),
        .reset (reset),
        .wr    (alu_pkt.slave),
        .rd    (fifo_pkt.master)
    );

    alu_writeback #(.NUM_THREADS(NUM_THREADS)) alu_writeback_i (
        .clk          (clk),
        .reset        (reset),
        .pkt          (fifo_pkt.slave),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_wid   (commit_wid),
        .commit_tmask (commit_tmask),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_unit #(
    parameter int NUM_THREADS = 4
) (
    input  wire                          clk,
    input  wire                          reset,
    alu_req_if.slave                     alu_req,
    output logic                         branch_valid,
    output logic                         branch_taken,
    output logic [simt_pkg::NW_BITS-1:0] branch_wid,
    output logic [simt_pkg::XLEN-1:0]    branch_dest,
    commit_if.master                     result
);

    localparam int XLEN = simt_pkg::XLEN;

    logic [NUM_THREADS-1:0][XLEN-1:0] alu_result;

    wire is_signed = (alu_req.op == simt_pkg::SLT);

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        wire [XLEN-1:0] a   = alu_req.a_data[i];
        wire [XLEN-1:0] b   = alu_req.b_data[i];
        wire [XLEN-1:0] rs1 = alu_req.rs1_data[i];
        wire [XLEN:0]   lt_diff = {is_signed & rs1[XLEN-1], rs1} - {is_signed & b[XLEN-1], b};

        always_comb begin
            case (alu_req.op)
                simt_pkg::SUB:  alu_result[i] = a - b;
                simt_pkg::SLT,
                simt_pkg::SLTU: alu_result[i] = {{(XLEN-1){1'b0}}, lt_diff[XLEN]};
                simt_pkg::AND:  alu_result[i] = rs1 & b;
                simt_pkg::OR:   alu_result[i] = rs1 | b;
                simt_pkg::XOR:  alu_result[i] = rs1 ^ b;
                simt_pkg::SLL:  alu_result[i] = rs1 << b[4:0];
                simt_pkg::SRL:  alu_result[i] = rs1 >> b[4:0];
                simt_pkg::SRA:  alu_result[i] = XLEN'($signed(rs1) >>> b[4:0]);
                default:        alu_result[i] = a + b;     // ADD, LUI, AUIPC
            endcase
        end
    end

    // Branch resolution on the selected lane
    wire br_signed = (alu_req.br_op == simt_pkg::BLT) || (alu_req.br_op == simt_pkg::BGE);

    wire [XLEN-1:0] cmp_a    = alu_req.rs1_data[alu_req.tid];
    wire [XLEN-1:0] cmp_b    = alu_req.rs2_data[alu_req.tid];
    wire [XLEN:0]   cmp_diff = {br_signed & cmp_a[XLEN-1], cmp_a}
                             - {br_signed & cmp_b[XLEN-1], cmp_b};
    wire            is_less  = cmp_diff[XLEN];
    wire            is_equal = (cmp_a == cmp_b);
    wire [XLEN-1:0] br_dest  = alu_req.a_data[alu_req.tid] + alu_req.imm;
    wire [XLEN-1:0] next_pc  = alu_req.pc + XLEN'(4);

    logic             is_br_r;
    simt_pkg::br_op_e br_op_r;
    logic             is_less_r;
    logic             is_equal_r;
    logic [XLEN-1:0]  br_dest_r;

    wire ready_in = result.ready || !result.valid;

    assign alu_req.ready = ready_in;

    always_ff @(posedge clk) begin
        if (reset)
            result.valid <= 1'b0;
        else if (ready_in)
            result.valid <= alu_req.valid;
    end

    always_ff @(posedge clk) begin
        if (ready_in) begin
            result.wid   <= alu_req.wid;
            result.tmask <= alu_req.tmask;
            result.pc    <= alu_req.pc;
            result.rd    <= alu_req.rd;
            result.wb    <= alu_req.wb;
            result.data  <= alu_req.is_br ? {NUM_THREADS{next_pc}} : alu_result;  // Link value
            is_br_r      <= alu_req.is_br;
            br_op_r      <= alu_req.br_op;
            is_less_r    <= is_less;
            is_equal_r   <= is_equal;
            br_dest_r    <= br_dest;
        end
    end

    always_comb begin
        case (br_op_r)
            simt_pkg::BEQ:  branch_taken = is_equal_r;
            simt_pkg::BNE:  branch_taken = !is_equal_r;
            simt_pkg::BLT,
            simt_pkg::BLTU: branch_taken = is_less_r;
            simt_pkg::BGE,
            simt_pkg::BGEU: branch_taken = !is_less_r;
            default:        branch_taken = 1'b1;           // JAL, JALR
        endcase
    end

    // Pulse only when the branch packet leaves for the FIFO
    assign branch_valid = result.valid && result.ready && is_br_r;
    assign branch_wid   = result.wid;
    assign branch_dest  = br_dest_r;

endmodule

`default_nettype wire

/* alu_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_writeback #(
    parameter int NUM_THREADS = 4
) (
    input  wire                                        clk,
    input  wire                                        reset,
    commit_if.slave                                    pkt,
    output logic                                       commit_valid,
    input  wire                                        commit_ready,
    output logic [simt_pkg::NW_BITS-1:0]               commit_wid,
    output logic [NUM_THREADS-1:0]                     commit_tmask,
    output logic [simt_pkg::XLEN-1:0]                  commit_pc,
    output logic [simt_pkg::NR_BITS-1:0]               commit_rd,
    output logic                                       commit_wb,
    output logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] commit_data
);

    // Refills in the same cycle the register drains
    assign pkt.ready = !commit_valid || commit_ready;

    always_ff @(posedge clk) begin
        if (reset)
            commit_valid <= 1'b0;
        else if (pkt.ready)
            commit_valid <= pkt.valid;
    end

    always_ff @(posedge clk) begin
        if (pkt.valid && pkt.ready) begin
            commit_wid   <= pkt.wid;
            commit_tmask <= pkt.tmask;
            commit_pc    <= pkt.pc;
            commit_rd    <= pkt.rd;
            commit_wb    <= pkt.wb && (pkt.rd != '0);   // x0 is never written
            for (int i = 0; i < NUM_THREADS; i++)
                commit_data[i] <= pkt.tmask[i] ? pkt.data[i] : '0;
        end
    end

endmodule

`default_nettype wire

/* commit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module commit_fifo #(
    parameter int NUM_THREADS = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  wire      clk,
    input  wire      reset,
    commit_if.slave  wr,
    commit_if.master rd
);

    localparam int ADDR_BITS = $clog2(FIFO_DEPTH);
    localparam int WIDTH     = simt_pkg::NW_BITS + NUM_THREADS + simt_pkg::XLEN
                             + simt_pkg::NR_BITS + 1 + NUM_THREADS * simt_pkg::XLEN;

    logic [WIDTH-1:0]     mem [FIFO_DEPTH];
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [ADDR_BITS:0]   count;

    wire full = (count == (ADDR_BITS+1)'(FIFO_DEPTH));
    wire push = wr.valid && wr.ready;
    wire pop  = rd.valid && rd.ready;

    assign rd.valid = (count != '0);
    assign wr.ready = !full || rd.ready;    // Full FIFO still takes a write while draining

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= {wr.wid, wr.tmask, wr.pc, wr.rd, wr.wb, wr.data};
    end

    assign {rd.wid, rd.tmask, rd.pc, rd.rd, rd.wb, rd.data} = mem[rd_ptr];

endmodule

`default_nettype wire

/* commit_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface commit_if #(
    parameter int NUM_THREADS = 4
);
    logic                                       valid;
    logic                                       ready;
    logic [simt_pkg::NW_BITS-1:0]               wid;
    logic [NUM_THREADS-1:0]                     tmask;
    logic [simt_pkg::XLEN-1:0]                  pc;
    logic [simt_pkg::NR_BITS-1:0]               rd;
    logic                                       wb;
    logic [NUM_THREADS-1:0][simt_pkg::XLEN-1:0] data;

    modport master (
        output valid, wid, tmask, pc, rd, wb, data,
        input  ready
    );

    modport slave (
        input  valid, wid, tmask, pc, rd, wb, data,
        output ready
    );

endinterface

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

/* simt_pkg.sv */
`default_nettype none

package simt_pkg;

    localparam int XLEN    = 32;
    localparam int NW_BITS = 2;     // Warp ID
    localparam int NR_BITS = 5;     // Destination register index

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU,
        AND, OR, XOR,
        SLL, SRL, SRA,
        LUI, AUIPC
    } alu_op_e;

    // Conditional kinds first, jumps last
    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } br_op_e;

    // Lane index width, at least one bit
    function automatic int tid_bits(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

/* src.f */
+incdir+.
simt_pkg.sv
alu_req_if.sv
commit_if.sv
alu_dispatch.sv
alu_unit.sv
commit_fifo.sv
alu_writeback.sv
alu_top.sv
alu_tb.sv
